// File: rtl/l2_cache_config.svh
`ifndef L2_CACHE_CONFIG_SVH
`define L2_CACHE_CONFIG_SVH

// cache geometry
`define L2_SETS     32
`define L2_WAYS     2

// block address and line widths
`define L2_ADDR_W   28
`define L2_LINE_W   128

`define L2_INDEX_W  $clog2(`L2_SETS)
`define L2_TAG_W    (`L2_ADDR_W - `L2_INDEX_W)

`endif

// File: rtl/l2_cache_pkg.sv
`include "l2_cache_config.svh"

package l2_cache_pkg;

    typedef logic [`L2_ADDR_W-1:0]  block_addr_t;
    typedef logic [`L2_TAG_W-1:0]   tag_t;
    typedef logic [`L2_INDEX_W-1:0] set_idx_t;
    typedef logic [`L2_LINE_W-1:0]  line_t;

    // one bit is enough for two ways
    typedef logic way_t;

    // per-way bookkeeping kept next to the tag
    typedef struct packed
    {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    // both ways at one set, index is the way
    typedef tag_entry_t [`L2_WAYS-1:0] tag_pair_t;
    typedef line_t [`L2_WAYS-1:0]      line_pair_t;

    // LOOKUP serves hits, the other two run a Wishbone transfer each
    typedef enum logic [1:0]
    {
        LOOKUP    = 2'd0,
        WRITEBACK = 2'd1,
        REFILL    = 2'd2
    } ctrl_state_t;

endpackage

// File: rtl/way_array.sv
`timescale 1ns/1ps

`include "l2_cache_config.svh"

module way_array
#(
    parameter type entry_t = l2_cache_pkg::line_t
)
(
    input  logic                   clk,
    input  logic                   proc_reset,
    input  l2_cache_pkg::set_idx_t index,
    input  logic                   wr_en,
    input  l2_cache_pkg::way_t     wr_way,
    input  entry_t                 wr_entry,
    output entry_t [1:0]           rd_pair
);

    // one row per set, both ways side by side
    entry_t [1:0] store [`L2_SETS];

    integer i;

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            for (i = 0; i < `L2_SETS; i = i + 1)
            begin
                store[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            store[index][wr_way] <= wr_entry;
        end
    end

    // read is combinational so a hit answers in the request cycle
    assign rd_pair = store[index];

endmodule

// File: rtl/hit_lookup.sv
`timescale 1ns/1ps

`include "l2_cache_config.svh"

module hit_lookup
(
    input  logic                    clk,
    input  logic                    proc_reset,
    input  l2_cache_pkg::set_idx_t  index,
    input  l2_cache_pkg::tag_t      req_tag,
    input  l2_cache_pkg::tag_pair_t tags,
    input  logic                    lru_touch,
    input  l2_cache_pkg::way_t      touch_way,
    output logic                    hit,
    output l2_cache_pkg::way_t      hit_way,
    output l2_cache_pkg::way_t      victim_way,
    output logic                    victim_dirty,
    output l2_cache_pkg::tag_t      victim_tag
);

    logic hit0;
    logic hit1;

    // one bit per set, names the least recently used way
    logic [`L2_SETS-1:0] lru;

    assign hit0 = tags[0].valid && (tags[0].tag == req_tag);
    assign hit1 = tags[1].valid && (tags[1].tag == req_tag);

    assign hit     = hit0 | hit1;
    assign hit_way = hit1;

    // fill an empty way before evicting anything
    always_comb
    begin
        if (!tags[0].valid)
        begin
            victim_way = 1'b0;
        end
        else if (!tags[1].valid)
        begin
            victim_way = 1'b1;
        end
        else
        begin
            victim_way = lru[index];
        end
    end

    assign victim_dirty = tags[victim_way].valid && tags[victim_way].dirty;
    assign victim_tag   = tags[victim_way].tag;

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            lru <= '0;
        end
        else if (lru_touch)
        begin
            lru[index] <= ~touch_way;
        end
    end

    // a refill only ever lands on a tag that missed, so a duplicate
    // means the controller wrote the wrong way at some earlier point
    a_no_double_hit : assert property (
        @(posedge clk) disable iff (proc_reset)
        !(hit0 && hit1)
    );

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
(
    input  logic               clk,
    input  logic               proc_reset,
    input  logic               proc_read,
    input  logic               proc_write,
    input  logic               hit,
    input  logic               victim_dirty,
    input  l2_cache_pkg::way_t hit_way,
    input  l2_cache_pkg::way_t victim_way,
    input  logic               wb_ack,
    output logic               proc_stall,
    output logic               tag_wr_en,
    output logic               data_wr_en,
    output l2_cache_pkg::way_t wr_way,
    output logic               fill_sel,
    output logic               lru_touch,
    output l2_cache_pkg::way_t touch_way,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we
);

    l2_cache_pkg::ctrl_state_t state;
    l2_cache_pkg::ctrl_state_t state_next;

    logic req;
    logic lookup_hit;
    logic bus_active;
    logic xfer_done;

    // idle cycle between the write-back ack and the refill strobe
    logic wb_gap;

    assign req        = proc_read | proc_write;
    assign lookup_hit = (state == l2_cache_pkg::LOOKUP) && req && hit;

    assign bus_active = ((state == l2_cache_pkg::WRITEBACK) ||
                         (state == l2_cache_pkg::REFILL)) && !wb_gap;
    assign xfer_done  = bus_active && wb_ack;

    always_comb
    begin
        state_next = state;
        case (state)
            l2_cache_pkg::LOOKUP:
            begin
                if (req && !hit)
                begin
                    state_next = victim_dirty ? l2_cache_pkg::WRITEBACK
                                              : l2_cache_pkg::REFILL;
                end
            end
            l2_cache_pkg::WRITEBACK:
            begin
                if (xfer_done)
                begin
                    state_next = l2_cache_pkg::REFILL;
                end
            end
            l2_cache_pkg::REFILL:
            begin
                if (xfer_done)
                begin
                    state_next = l2_cache_pkg::LOOKUP;
                end
            end
            default:
            begin
                state_next = l2_cache_pkg::LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state  <= l2_cache_pkg::LOOKUP;
            wb_gap <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            wb_gap <= (state == l2_cache_pkg::WRITEBACK) && xfer_done;
        end
    end

    // held request hits in the cycle after the refill ack
    assign proc_stall = proc_reset || (state != l2_cache_pkg::LOOKUP) || (req && !hit);

    // write hit stores data and a dirty tag, refill stores a clean line
    assign fill_sel   = (state == l2_cache_pkg::REFILL);
    assign tag_wr_en  = (lookup_hit && proc_write) || (fill_sel && xfer_done);
    assign data_wr_en = tag_wr_en;
    assign wr_way     = fill_sel ? victim_way : hit_way;

    assign lru_touch = lookup_hit;
    assign touch_way = hit_way;

    assign wb_cyc = bus_active;
    assign wb_stb = bus_active;
    assign wb_we  = bus_active && (state == l2_cache_pkg::WRITEBACK);

    // stb and cyc stay up until the slave acks
    a_stb_until_ack : assert property (
        @(posedge clk) disable iff (proc_reset)
        wb_stb && !wb_ack |=> wb_stb && wb_cyc
    );

    a_read_write_excl : assert property (
        @(posedge clk) disable iff (proc_reset)
        !(proc_read && proc_write)
    );

    // a new transfer starts only from a missed request or after the write-back gap
    a_cyc_only_on_miss : assert property (
        @(posedge clk) disable iff (proc_reset)
        $rose(wb_cyc) |-> ($past(req && !hit) || $past(wb_gap))
    );

endmodule

// File: rtl/l2_cache_top.sv
`timescale 1ns/1ps

`include "l2_cache_config.svh"

module l2_cache_top
(
    input  logic                      clk,
    input  logic                      proc_reset,
    input  logic                      proc_read,
    input  logic                      proc_write,
    input  l2_cache_pkg::block_addr_t proc_addr,
    input  l2_cache_pkg::line_t       proc_wdata,
    output l2_cache_pkg::line_t       proc_rdata,
    output logic                      proc_stall,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output l2_cache_pkg::block_addr_t wb_adr,
    output l2_cache_pkg::line_t       wb_dat_o,
    input  l2_cache_pkg::line_t       wb_dat_i,
    input  logic                      wb_ack
);

    l2_cache_pkg::tag_t       req_tag;
    l2_cache_pkg::set_idx_t   index;

    l2_cache_pkg::tag_pair_t  tags;
    l2_cache_pkg::line_pair_t lines;

    logic                     hit;
    l2_cache_pkg::way_t       hit_way;
    l2_cache_pkg::way_t       victim_way;
    logic                     victim_dirty;
    l2_cache_pkg::tag_t       victim_tag;

    logic                     tag_wr_en;
    logic                     data_wr_en;
    l2_cache_pkg::way_t       wr_way;
    logic                     fill_sel;
    logic                     lru_touch;
    l2_cache_pkg::way_t       touch_way;

    l2_cache_pkg::tag_entry_t wr_tag_entry;
    l2_cache_pkg::line_t      wr_line;

    // block address is {tag, set index}
    assign req_tag = proc_addr[`L2_ADDR_W-1:`L2_INDEX_W];
    assign index   = proc_addr[`L2_INDEX_W-1:0];

    // refill brings a clean line, a write hit leaves the line dirty
    assign wr_line      = fill_sel ? wb_dat_i : proc_wdata;
    assign wr_tag_entry = '{valid: 1'b1, dirty: !fill_sel, tag: req_tag};

    way_array #(
        .entry_t    (l2_cache_pkg::tag_entry_t)
    ) tag_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .wr_en      (tag_wr_en),
        .wr_way     (wr_way),
        .wr_entry   (wr_tag_entry),
        .rd_pair    (tags)
    );

    way_array #(
        .entry_t    (l2_cache_pkg::line_t)
    ) data_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .wr_en      (data_wr_en),
        .wr_way     (wr_way),
        .wr_entry   (wr_line),
        .rd_pair    (lines)
    );

    hit_lookup hit_lookup_i (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (index),
        .req_tag      (req_tag),
        .tags         (tags),
        .lru_touch    (lru_touch),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_ctrl cache_ctrl_i (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .wb_ack       (wb_ack),
        .proc_stall   (proc_stall),
        .tag_wr_en    (tag_wr_en),
        .data_wr_en   (data_wr_en),
        .wr_way       (wr_way),
        .fill_sel     (fill_sel),
        .lru_touch    (lru_touch),
        .touch_way    (touch_way),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we)
    );

    assign proc_rdata = hit ? lines[hit_way] : '0;

    // wb_we is high only while the dirty victim goes out
    assign wb_adr   = wb_we ? {victim_tag, index} : proc_addr;
    assign wb_dat_o = lines[victim_way];

endmodule

// File: tests/mem_model.sv
`timescale 1ns/1ps

module mem_model
(
    input  logic                      clk,
    input  logic                      proc_reset,
    input  logic [3:0]                wait_states,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  l2_cache_pkg::block_addr_t wb_adr,
    input  l2_cache_pkg::line_t       wb_dat_i,
    output l2_cache_pkg::line_t       wb_dat_o,
    output logic                      wb_ack
);

    // only lines written back by the cache are stored
    l2_cache_pkg::line_t mem [l2_cache_pkg::block_addr_t];

    logic [3:0] waited;

    function automatic l2_cache_pkg::line_t initial_line(input l2_cache_pkg::block_addr_t adr);
        logic [31:0] a;
        a = {4'h0, adr};
        return {a * 32'h9e37_79b1, ~a, {a[15:0], a[27:12]}, a ^ 32'h5a5a_c3c3};
    endfunction

    always @(posedge clk)
    begin
        if (proc_reset)
        begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
            waited   <= '0;
        end
        else if (wb_ack)
        begin
            // master drops cyc and stb after the ack
            wb_ack <= 1'b0;
        end
        else if (wb_cyc && wb_stb)
        begin
            if (waited >= wait_states)
            begin
                wb_ack <= 1'b1;
                waited <= '0;
                if (wb_we)
                    mem[wb_adr] = wb_dat_i;
                else
                    wb_dat_o <= mem.exists(wb_adr) ? mem[wb_adr] : initial_line(wb_adr);
            end
            else
                waited <= waited + 1'b1;
        end
    end

endmodule

// File: tests/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb;

    localparam logic [31:0] LFSR_SEED      = 32'h4d1c_b2a5;
    localparam int          TIMEOUT_CYCLES = 20000;
    localparam int          WAIT_BITS      = 3;
    localparam int          RANDOM_OPS     = 200;

    logic                      clk;
    logic                      proc_reset;
    logic                      proc_read;
    logic                      proc_write;
    l2_cache_pkg::block_addr_t proc_addr;
    l2_cache_pkg::line_t       proc_wdata;
    l2_cache_pkg::line_t       proc_rdata;
    logic                      proc_stall;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    l2_cache_pkg::block_addr_t wb_adr;
    l2_cache_pkg::line_t       wb_dat_o;
    l2_cache_pkg::line_t       wb_dat_i;
    logic                      wb_ack;
    logic [3:0]                mem_wait;

    logic [31:0]               lfsr;
    int                        cycle_count = 0;
    int                        error_count = 0;
    int                        tests_run = 0;
    int                        tests_failed = 0;
    int                        bus_reads = 0;
    int                        bus_writes = 0;
    int                        snap_reads;
    int                        snap_writes;
    l2_cache_pkg::block_addr_t last_wr_adr;
    l2_cache_pkg::line_t       last_wr_dat;

    // every processor write, by block address
    l2_cache_pkg::line_t shadow [l2_cache_pkg::block_addr_t];

    l2_cache_top l2_cache_top_i (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_o   (wb_dat_o),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack)
    );

    mem_model mem_i (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .wait_states (mem_wait),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_o),
        .wb_dat_o    (wb_dat_i),
        .wb_ack      (wb_ack)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // completed Wishbone transfers
    always @(posedge clk)
    begin
        if (wb_cyc && wb_stb && wb_ack)
        begin
            if (wb_we)
            begin
                bus_writes  <= bus_writes + 1;
                last_wr_adr <= wb_adr;
                last_wr_dat <= wb_dat_o;
            end
            else
                bus_reads <= bus_reads + 1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, a request never completed", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [127:0] bits);
        int k;
        bits = '0;
        for (k = 0; k < n; k++)
        begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[126:0], lfsr[0]};
        end
    endtask

    function automatic l2_cache_pkg::line_t fill_pattern(input l2_cache_pkg::block_addr_t adr);
        logic [31:0] a;
        a = {4'h0, adr};
        return {a * 32'h9e37_79b1, ~a, {a[15:0], a[27:12]}, a ^ 32'h5a5a_c3c3};
    endfunction

    function automatic l2_cache_pkg::line_t expected_line(input l2_cache_pkg::block_addr_t adr);
        if (shadow.exists(adr))
            return shadow[adr];
        return fill_pattern(adr);
    endfunction

    function automatic l2_cache_pkg::block_addr_t make_addr(input l2_cache_pkg::tag_t tag,
                                                           input l2_cache_pkg::set_idx_t set);
        return {tag, set};
    endfunction

    task automatic report_mismatch(input string test, input l2_cache_pkg::line_t expected,
                                   input l2_cache_pkg::line_t actual);
        $display("** Error %s: expected %h, actual %h", test, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string test, input string what);
        $display("%s: %s", test, what);
        error_count++;
    endtask

    task automatic finish_test(input string test, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
            $display("%s: ok", test);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", test, error_count - errors_before);
        end
    endtask

    // request held until stall is low, taken at the next edge
    task automatic access(input logic write, input l2_cache_pkg::block_addr_t adr,
                          input l2_cache_pkg::line_t wdata, output l2_cache_pkg::line_t rdata);
        @(posedge clk);
        proc_read  <= !write;
        proc_write <= write;
        proc_addr  <= adr;
        proc_wdata <= wdata;
        @(negedge clk);
        while (proc_stall)
            @(negedge clk);
        rdata = proc_rdata;
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        if (write)
            shadow[adr] = wdata;
    endtask

    task automatic mark_bus();
        snap_reads  = bus_reads;
        snap_writes = bus_writes;
    endtask

    task automatic check_bus(input string test, input int reads, input int writes);
        if (bus_reads - snap_reads != reads)
            report_failure(test, $sformatf("saw %0d bus reads, wanted %0d",
                                           bus_reads - snap_reads, reads));
        if (bus_writes - snap_writes != writes)
            report_failure(test, $sformatf("saw %0d bus writes, wanted %0d",
                                           bus_writes - snap_writes, writes));
    endtask

    task automatic check_read(input string test, input l2_cache_pkg::block_addr_t adr,
                              input l2_cache_pkg::line_t data);
        if (data !== expected_line(adr))
            report_mismatch(test, expected_line(adr), data);
    endtask

    // outputs while reset is still asserted
    task automatic reset_state();
        int errors_before;
        errors_before = error_count;
        if (proc_stall !== 1'b1)
            report_failure("reset_state", "proc_stall is not high during reset");
        if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || wb_we !== 1'b0)
            report_failure("reset_state", "Wishbone cyc, stb or we is active during reset");
        finish_test("reset_state", errors_before);
    endtask

    task automatic cold_read();
        l2_cache_pkg::block_addr_t adr;
        l2_cache_pkg::line_t       data;
        int                        errors_before;
        errors_before = error_count;
        adr = make_addr(23'h01_a2b3, 5'd3);
        mark_bus();
        access(1'b0, adr, '0, data);
        check_read("cold_read", adr, data);
        check_bus("cold_read", 1, 0);
        mark_bus();
        access(1'b0, adr, '0, data);
        check_read("cold_read", adr, data);
        check_bus("cold_read", 0, 0);
        finish_test("cold_read", errors_before);
    endtask

    task automatic write_hit();
        l2_cache_pkg::block_addr_t adr;
        l2_cache_pkg::line_t       data;
        logic [127:0]              wdata;
        int                        errors_before;
        errors_before = error_count;
        adr = make_addr(23'h01_a2b3, 5'd3);
        random_bits(128, wdata);
        mark_bus();
        access(1'b1, adr, wdata, data);
        access(1'b0, adr, '0, data);
        check_read("write_hit", adr, data);
        check_bus("write_hit", 0, 0);
        finish_test("write_hit", errors_before);
    endtask

    task automatic two_way_set();
        l2_cache_pkg::block_addr_t a;
        l2_cache_pkg::block_addr_t b;
        l2_cache_pkg::line_t       data;
        int                        errors_before;
        int                        i;
        errors_before = error_count;
        a = make_addr(23'h00_0111, 5'd7);
        b = make_addr(23'h00_0222, 5'd7);
        mark_bus();
        access(1'b0, a, '0, data);
        check_read("two_way_set", a, data);
        access(1'b0, b, '0, data);
        check_read("two_way_set", b, data);
        check_bus("two_way_set", 2, 0);
        mark_bus();
        for (i = 0; i < 6; i++)
        begin
            access(1'b0, i[0] ? b : a, '0, data);
            check_read("two_way_set", i[0] ? b : a, data);
        end
        check_bus("two_way_set", 0, 0);
        finish_test("two_way_set", errors_before);
    endtask

    task automatic dirty_eviction();
        l2_cache_pkg::block_addr_t a;
        l2_cache_pkg::block_addr_t b;
        l2_cache_pkg::block_addr_t c;
        l2_cache_pkg::block_addr_t d;
        l2_cache_pkg::line_t       data;
        logic [127:0]              wdata;
        int                        errors_before;
        errors_before = error_count;
        a = make_addr(23'h00_0aaa, 5'd12);
        b = make_addr(23'h00_0bbb, 5'd12);
        c = make_addr(23'h00_0ccc, 5'd12);
        d = make_addr(23'h00_0ddd, 5'd12);
        random_bits(128, wdata);
        mark_bus();
        access(1'b1, a, wdata, data);
        access(1'b0, b, '0, data);
        check_read("dirty_eviction", b, data);
        access(1'b0, a, '0, data);
        check_read("dirty_eviction", a, data);
        check_bus("dirty_eviction", 2, 0);
        // b is now the LRU way and clean
        mark_bus();
        access(1'b0, c, '0, data);
        check_read("dirty_eviction", c, data);
        check_bus("dirty_eviction", 1, 0);
        mark_bus();
        access(1'b0, d, '0, data);
        check_read("dirty_eviction", d, data);
        check_bus("dirty_eviction", 1, 1);
        if (last_wr_adr !== a)
            report_mismatch("dirty_eviction", l2_cache_pkg::line_t'(a),
                            l2_cache_pkg::line_t'(last_wr_adr));
        if (last_wr_dat !== wdata)
            report_mismatch("dirty_eviction", wdata, last_wr_dat);
        access(1'b0, a, '0, data);
        check_read("dirty_eviction", a, data);
        finish_test("dirty_eviction", errors_before);
    endtask

    task automatic random_traffic();
        l2_cache_pkg::block_addr_t adr;
        l2_cache_pkg::line_t       data;
        logic [127:0]              bits;
        logic [127:0]              wdata;
        logic                      write;
        int                        errors_before;
        int                        i;
        errors_before = error_count;
        for (i = 0; i < RANDOM_OPS; i++)
        begin
            random_bits(2, bits);
            adr[4:0] = {3'b100, bits[1:0]};
            random_bits(3, bits);
            adr[27:5] = {20'h0_0040, bits[2:0]};
            random_bits(WAIT_BITS, bits);
            mem_wait <= bits[3:0];
            random_bits(1, bits);
            write = bits[0];
            wdata = '0;
            if (write)
                random_bits(128, wdata);
            access(write, adr, wdata, data);
            if (!write)
                check_read("random_traffic", adr, data);
        end
        finish_test("random_traffic", errors_before);
    endtask

    initial
    begin
        lfsr       = LFSR_SEED;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        mem_wait   = '0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        reset_state();
        @(posedge clk);
        proc_reset <= 1'b0;

        cold_read();
        write_hit();
        two_way_set();
        dirty_eviction();
        random_traffic();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/l2_cache_pkg.sv
rtl/way_array.sv
rtl/hit_lookup.sv
rtl/cache_ctrl.sv
rtl/l2_cache_top.sv
tests/mem_model.sv
tests/l2_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= l2_cache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
